// ==== cpu_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_alu (
    input  cpu_pkg::alu_op_e op_i,
    input  cpu_pkg::data_t   a_i,
    input  cpu_pkg::data_t   b_i,
    input  logic             carry_i,
    output cpu_pkg::data_t   result_o,
    output logic             carry_o,
    output logic             overflow_o
);
    import cpu_pkg::*;

    logic [data_w:0] sum;
    data_t           operand_b;
    logic            carry_in;

    always_comb begin
        // subtract is add of the complement, carry acts as not-borrow
        // inc and dec share the adder with fixed operands
        case (op_i)
            alu_sbc: begin
                operand_b = ~b_i;
                carry_in = carry_i;
            end
            alu_inc: begin
                operand_b = '0;
                carry_in = 1'b1;
            end
            alu_dec: begin
                operand_b = '1;
                carry_in = 1'b0;
            end
            default: begin
                operand_b = b_i;
                carry_in = carry_i;
            end
        endcase
        sum = {1'b0, a_i} + {1'b0, operand_b} + {{data_w{1'b0}}, carry_in};
        carry_o = sum[data_w];
        // same operand signs but result sign differs
        overflow_o = (a_i[data_w-1] == operand_b[data_w-1]) &&
                     (sum[data_w-1] != a_i[data_w-1]);
        case (op_i)
            alu_adc, alu_sbc, alu_inc, alu_dec: result_o = sum[data_w-1:0];
            alu_and:          result_o = a_i & b_i;
            alu_or:           result_o = a_i | b_i;
            alu_eor:          result_o = a_i ^ b_i;
            default:          result_o = a_i;
        endcase
    end

    always_comb begin
        if (op_i == alu_inc) begin
            assert (result_o == data_t'(a_i + data_t'(1)));
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::addr_t reset_addr = 16'h0200
) (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::data_t data_i,
    output cpu_pkg::addr_t addr_o,
    output cpu_pkg::data_t data_o,
    output logic           rw_o,
    output logic           sync_o
);
    import cpu_pkg::*;

    decoded_t dec;
    data_t    opcode;
    logic     take_branch;

    cpu_ctrl_if ctrl_if ();

    cpu_timing timing_inst (
        .clk           (clk),
        .rst           (rst),
        .dec_i         (dec),
        .take_branch_i (take_branch),
        .ctrl          (ctrl_if.ctrl),
        .sync_o        (sync_o)
    );

    cpu_decode decode_inst (
        .opcode_i (opcode),
        .dec_o    (dec)
    );

    cpu_datapath #(
        .reset_addr (reset_addr)
    ) datapath_inst (
        .clk           (clk),
        .rst           (rst),
        .data_i        (data_i),
        .dec_i         (dec),
        .ctrl          (ctrl_if.path),
        .opcode_o      (opcode),
        .take_branch_o (take_branch),
        .addr_o        (addr_o),
        .data_o        (data_o),
        .rw_o          (rw_o)
    );

endmodule

`default_nettype wire

// ==== cpu_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface cpu_ctrl_if;
    import cpu_pkg::*;

    addr_src_e adl_src;
    addr_src_e adh_src;
    logic      inc_pc;
    logic      jump;
    logic      load_ir;
    logic      exec;
    logic      write_mem;
    // pc plus signed operand, taken branches only
    logic      branch_add;

    modport ctrl (output adl_src, adh_src, inc_pc, jump, load_ir, exec, write_mem, branch_add);

    modport path (input adl_src, adh_src, inc_pc, jump, load_ir, exec, write_mem, branch_add);

endinterface

`default_nettype wire

// ==== cpu_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath #(
    parameter cpu_pkg::addr_t reset_addr = 16'h0200
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::data_t    data_i,
    input  cpu_pkg::decoded_t dec_i,
    cpu_ctrl_if.path          ctrl,
    output cpu_pkg::data_t    opcode_o,
    output logic              take_branch_o,
    output cpu_pkg::addr_t    addr_o,
    output cpu_pkg::data_t    data_o,
    output logic              rw_o
);
    import cpu_pkg::*;

    addr_t pc_reg;
    addr_t pc_next;
    data_t ir_reg;
    data_t operand;
    data_t a_reg;
    data_t x_reg;
    data_t y_reg;
    data_t p_reg;
    data_t src_val;
    data_t alu_result;
    data_t adl;
    data_t adh;
    logic  alu_carry;
    logic  alu_overflow;

    always_comb begin
        case (dec_i.src)
            sel_a:   src_val = a_reg;
            sel_x:   src_val = x_reg;
            sel_y:   src_val = y_reg;
            sel_mem: src_val = data_i;
            default: src_val = '0;
        endcase
    end

    cpu_alu alu_inst (
        .op_i       (dec_i.alu_op),
        .a_i        (src_val),
        .b_i        (data_i),
        .carry_i    (p_reg[flag_c]),
        .result_o   (alu_result),
        .carry_o    (alu_carry),
        .overflow_o (alu_overflow)
    );

    assign take_branch_o = (p_reg[dec_i.br_flag] == dec_i.br_pol);
    assign opcode_o = ir_reg;

    // address bytes, the pc source is the already advanced pc
    always_comb begin
        pc_next = pc_reg;
        if (ctrl.branch_add) begin
            pc_next = pc_reg + {{(addr_w - data_w){operand[data_w-1]}}, operand};
        end else if (ctrl.inc_pc) begin
            pc_next = pc_reg + addr_t'(1);
        end
        case (ctrl.adl_src)
            addr_data: adl = data_i;
            addr_zero: adl = '0;
            addr_hold: adl = operand;
            default:   adl = pc_next[data_w-1:0];
        endcase
        case (ctrl.adh_src)
            addr_data: adh = data_i;
            addr_zero: adh = '0;
            addr_hold: adh = operand;
            default:   adh = pc_next[addr_w-1:data_w];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_reg <= reset_addr;
            addr_o <= '0;
            ir_reg <= '0;
            rw_o <= 1'b1;
            data_o <= '0;
            p_reg <= status_reset;
        end else begin
            pc_reg <= ctrl.jump ? {adh, adl} : pc_next;
            addr_o <= {adh, adl};
            rw_o <= !ctrl.write_mem;
            if (ctrl.load_ir) begin
                ir_reg <= data_i;
            end
            if (ctrl.write_mem) begin
                data_o <= src_val;
            end
            if (ctrl.exec) begin
                if (dec_i.upd_nz) begin
                    p_reg[flag_z] <= (alu_result == '0);
                    p_reg[flag_n] <= alu_result[data_w-1];
                end
                if (dec_i.upd_c) begin
                    p_reg[flag_c] <= alu_carry;
                end
                if (dec_i.upd_v) begin
                    p_reg[flag_v] <= alu_overflow;
                end
                if (dec_i.set_c) begin
                    p_reg[flag_c] <= 1'b1;
                end
                if (dec_i.clr_c) begin
                    p_reg[flag_c] <= 1'b0;
                end
            end
        end
    end

    // operand latch follows the bus every cycle
    always_ff @(posedge clk) begin
        operand <= data_i;
        if (ctrl.exec) begin
            case (dec_i.dst)
                sel_a:   a_reg <= alu_result;
                sel_x:   x_reg <= alu_result;
                sel_y:   y_reg <= alu_result;
                default: begin
                end
            endcase
        end
    end

    a_status_bit5: assert property (@(posedge clk) disable iff (rst)
        (p_reg & status_reset) == status_reset);

endmodule

`default_nettype wire

// ==== cpu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_decode (
    input  cpu_pkg::data_t    opcode_i,
    output cpu_pkg::decoded_t dec_o
);
    import cpu_pkg::*;

    alu_op_e  grp1_op;
    logic     grp1_ok;
    reg_sel_e xy_sel;

    always_comb begin
        // aaa field of the cc=01 group
        grp1_ok = 1'b1;
        case (opcode_i[7:5])
            3'b000:  grp1_op = alu_or;
            3'b001:  grp1_op = alu_and;
            3'b010:  grp1_op = alu_eor;
            3'b011:  grp1_op = alu_adc;
            3'b111:  grp1_op = alu_sbc;
            default: begin
                // 101 is LDA, STA and CMP are not reads here
                grp1_op = alu_pass;
                grp1_ok = (opcode_i[7:5] == 3'b101);
            end
        endcase
        xy_sel = opcode_i[1] ? sel_x : sel_y;

        dec_o.cls = cls_implied;
        dec_o.alu_op = alu_pass;
        dec_o.src = sel_none;
        dec_o.dst = sel_none;
        dec_o.upd_nz = 1'b0;
        dec_o.upd_c = 1'b0;
        dec_o.upd_v = 1'b0;
        dec_o.set_c = 1'b0;
        dec_o.clr_c = 1'b0;
        dec_o.br_flag = flag_c;
        dec_o.br_pol = 1'b0;

        if (opcode_i ==? 8'b100_0?1_01) begin
            // STA zp / abs
            dec_o.cls = opcode_i[3] ? cls_abs_store : cls_zp_store;
            dec_o.src = sel_a;
        end else if (opcode_i ==? 8'b100_0?1_?0) begin
            // STX / STY zp / abs
            dec_o.cls = opcode_i[3] ? cls_abs_store : cls_zp_store;
            dec_o.src = xy_sel;
        end else if (opcode_i ==? 8'b101_00?_?0) begin
            // LDX / LDY imm / zp
            dec_o.cls = opcode_i[2] ? cls_zp_read : cls_imm;
            dec_o.src = sel_mem;
            dec_o.dst = xy_sel;
            dec_o.upd_nz = 1'b1;
        end else if (grp1_ok && (opcode_i ==? 8'b???_0??_01) && (opcode_i[3] != opcode_i[2])) begin
            // bbb 001 zp, 010 imm
            dec_o.cls = opcode_i[3] ? cls_imm : cls_zp_read;
            dec_o.alu_op = grp1_op;
            dec_o.src = (grp1_op == alu_pass) ? sel_mem : sel_a;
            dec_o.dst = sel_a;
            dec_o.upd_nz = 1'b1;
            dec_o.upd_c = (grp1_op == alu_adc) || (grp1_op == alu_sbc);
            dec_o.upd_v = (grp1_op == alu_adc) || (grp1_op == alu_sbc);
        end else if (opcode_i ==? 8'b1??_100_00) begin
            // bit 6 picks z or c, bit 5 the polarity
            dec_o.cls = cls_branch;
            dec_o.br_flag = opcode_i[6] ? flag_z : flag_c;
            dec_o.br_pol = opcode_i[5];
        end else if (opcode_i == 8'h4c) begin
            dec_o.cls = cls_jump;
        end else if (opcode_i ==? 8'b00?_110_00) begin
            // CLC / SEC
            dec_o.set_c = opcode_i[5];
            dec_o.clr_c = !opcode_i[5];
        end else if ((opcode_i ==? 8'b11?_010_00) || (opcode_i == 8'hca) ||
                     (opcode_i == 8'h88)) begin
            // INY C8, INX E8, DEX CA, DEY 88
            dec_o.alu_op = (opcode_i[6] && !opcode_i[1]) ? alu_inc : alu_dec;
            dec_o.src = (opcode_i[5] || opcode_i[1]) ? sel_x : sel_y;
            dec_o.dst = (opcode_i[5] || opcode_i[1]) ? sel_x : sel_y;
            dec_o.upd_nz = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 16;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    // bit 5 of the status register is wired high
    localparam data_t status_reset = 8'b0010_0000;

    // t1 fetch, t2 first operand, t3 second operand or branch, t0 memory cycle
    typedef enum logic [1:0] {t0, t1, t2, t3} t_state_e;

    typedef enum logic [2:0] {
        cls_implied,
        cls_imm,
        cls_zp_read,
        cls_zp_store,
        cls_abs_store,
        cls_jump,
        cls_branch
    } op_class_e;

    typedef enum logic [2:0] {
        alu_pass,
        alu_adc,
        alu_sbc,
        alu_and,
        alu_or,
        alu_eor,
        alu_inc,
        alu_dec
    } alu_op_e;

    typedef enum logic [1:0] {addr_pc, addr_data, addr_zero, addr_hold} addr_src_e;

    typedef enum logic [2:0] {sel_none, sel_a, sel_x, sel_y, sel_mem} reg_sel_e;

    typedef enum logic [2:0] {flag_c = 3'd0, flag_z = 3'd1, flag_v = 3'd6, flag_n = 3'd7} flag_e;

    typedef struct packed {
        op_class_e cls;
        alu_op_e   alu_op;
        reg_sel_e  src;
        reg_sel_e  dst;
        logic      upd_nz;
        logic      upd_c;
        logic      upd_v;
        logic      set_c;
        logic      clr_c;
        flag_e     br_flag;
        logic      br_pol;
    } decoded_t;

endpackage

`default_nettype wire

// ==== cpu_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_timing (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::decoded_t dec_i,
    input  logic              take_branch_i,
    cpu_ctrl_if.ctrl          ctrl,
    output logic              sync_o
);
    import cpu_pkg::*;

    t_state_e state;
    t_state_e state_next;

    // reset parks in t0 so the first free edge loads the fetch address
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= t0;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = t1;
        sync_o = 1'b0;
        ctrl.adl_src = addr_pc;
        ctrl.adh_src = addr_pc;
        ctrl.inc_pc = 1'b0;
        ctrl.jump = 1'b0;
        ctrl.load_ir = 1'b0;
        ctrl.exec = 1'b0;
        ctrl.write_mem = 1'b0;
        ctrl.branch_add = 1'b0;

        case (state)
            t1: begin
                // opcode on the bus, decode sees it next cycle
                sync_o = 1'b1;
                ctrl.load_ir = 1'b1;
                ctrl.inc_pc = 1'b1;
                state_next = t2;
            end
            t2: begin
                case (dec_i.cls)
                    cls_imm: begin
                        ctrl.exec = 1'b1;
                        ctrl.inc_pc = 1'b1;
                    end
                    cls_zp_read, cls_zp_store: begin
                        ctrl.inc_pc = 1'b1;
                        ctrl.adl_src = addr_data;
                        ctrl.adh_src = addr_zero;
                        ctrl.write_mem = (dec_i.cls == cls_zp_store);
                        state_next = t0;
                    end
                    cls_abs_store, cls_jump: begin
                        ctrl.inc_pc = 1'b1;
                        state_next = t3;
                    end
                    cls_branch: begin
                        ctrl.inc_pc = 1'b1;
                        if (take_branch_i) begin
                            state_next = t3;
                        end
                    end
                    default: begin
                        // implied and unknown opcodes
                        ctrl.exec = 1'b1;
                    end
                endcase
            end
            t3: begin
                case (dec_i.cls)
                    cls_abs_store: begin
                        ctrl.adl_src = addr_hold;
                        ctrl.adh_src = addr_data;
                        ctrl.inc_pc = 1'b1;
                        ctrl.write_mem = 1'b1;
                        state_next = t0;
                    end
                    cls_jump: begin
                        ctrl.adl_src = addr_hold;
                        ctrl.adh_src = addr_data;
                        ctrl.jump = 1'b1;
                    end
                    cls_branch: begin
                        ctrl.branch_add = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            t0: begin
                // memory byte of a zero-page read is on data_i now
                ctrl.exec = (dec_i.cls == cls_zp_read);
            end
        endcase
    end

    a_no_write_in_fetch: assert property (@(posedge clk) disable iff (rst)
        (state == t1) |-> !ctrl.write_mem);

    // the cycle after a write strobe is the write itself, never a fetch
    a_sync_not_after_write: assert property (@(posedge clk) disable iff (rst)
        ctrl.write_mem |=> !sync_o);

endmodule

`default_nettype wire

// ==== cpu_vectors.txt ====
# records: letter, hex address, hex byte (H has the address only)
# M preloads memory, W is the next expected write in program order, H is the halt fetch
M 0010 55 M 0011 0f M 0012 7f M 0013 33  # zero-page operands
M 0200 a9 M 0201 01                      # LDA #$01
M 0202 85 M 0203 80 W 0080 01            # STA $80
M 0204 a2 M 0205 ff                      # LDX #$FF
M 0206 a0 M 0207 10                      # LDY #$10
M 0208 86 M 0209 81 W 0081 ff            # STX $81
M 020a 84 M 020b 82 W 0082 10            # STY $82
M 020c a5 M 020d 10                      # LDA $10
M 020e a6 M 020f 11                      # LDX $11
M 0210 a4 M 0211 13                      # LDY $13
M 0212 8d M 0213 00 M 0214 03 W 0300 55  # STA $0300
M 0215 8e M 0216 01 M 0217 03 W 0301 0f  # STX $0301
M 0218 8c M 0219 02 M 021a 03 W 0302 33  # STY $0302
M 021b 18                                # CLC
M 021c 69 M 021d 0f                      # ADC #$0F  55+0f=64
M 021e 85 M 021f 83 W 0083 64            # STA $83
M 0220 38                                # SEC
M 0221 69 M 0222 a0                      # ADC #$A0  carry in and carry out
M 0223 85 M 0224 84 W 0084 05            # STA $84
M 0225 65 M 0226 12                      # ADC $12  05+7f+1 signed overflow
M 0227 85 M 0228 85 W 0085 85            # STA $85
M 0229 38                                # SEC
M 022a e9 M 022b 10                      # SBC #$10  85-10=75
M 022c 85 M 022d 86 W 0086 75            # STA $86
M 022e 18                                # CLC  borrow in
M 022f e5 M 0230 11                      # SBC $11  75-0f-1=65
M 0231 85 M 0232 87 W 0087 65            # STA $87
M 0233 29 M 0234 0f                      # AND #$0F
M 0235 85 M 0236 88 W 0088 05            # STA $88
M 0237 05 M 0238 10                      # ORA $10
M 0239 85 M 023a 89 W 0089 55            # STA $89
M 023b 49 M 023c ff                      # EOR #$FF
M 023d 85 M 023e 8a W 008a aa            # STA $8A
M 023f 25 M 0240 11                      # AND $11  0a
M 0241 09 M 0242 30                      # ORA #$30  3a
M 0243 45 M 0244 13                      # EOR $13  09
M 0245 85 M 0246 8b W 008b 09            # STA $8B
M 0247 e8 M 0248 c8                      # INX INY
M 0249 86 M 024a 8c W 008c 10            # STX $8C
M 024b 84 M 024c 8d W 008d 34            # STY $8D
M 024d ca M 024e 88                      # DEX DEY
M 024f 86 M 0250 8e W 008e 0f            # STX $8E
M 0251 84 M 0252 8f W 008f 33            # STY $8F
M 0253 a9 M 0254 00                      # LDA #$00  z set
M 0255 f0 M 0256 02 M 0257 a9 M 0258 ee  # BEQ taken over LDA #$EE
M 0259 85 M 025a 90 W 0090 00            # STA $90
M 025b d0 M 025c 02 M 025d a9 M 025e 21  # BNE not taken, LDA #$21
M 025f 85 M 0260 91 W 0091 21            # STA $91
M 0261 d0 M 0262 02 M 0263 a9 M 0264 ee  # BNE taken over LDA #$EE
M 0265 85 M 0266 92 W 0092 21            # STA $92
M 0267 f0 M 0268 02 M 0269 a9 M 026a 42  # BEQ not taken, LDA #$42
M 026b 85 M 026c 93 W 0093 42            # STA $93
M 026d 18                                # CLC
M 026e 90 M 026f 02 M 0270 a9 M 0271 ee  # BCC taken over LDA #$EE
M 0272 85 M 0273 94 W 0094 42            # STA $94
M 0274 b0 M 0275 02 M 0276 a9 M 0277 63  # BCS not taken, LDA #$63
M 0278 85 M 0279 95 W 0095 63            # STA $95
M 027a 38                                # SEC
M 027b b0 M 027c 02 M 027d a9 M 027e ee  # BCS taken over LDA #$EE
M 027f 85 M 0280 96 W 0096 63            # STA $96
M 0281 90 M 0282 02 M 0283 a9 M 0284 84  # BCC not taken, LDA #$84
M 0285 85 M 0286 97 W 0097 84            # STA $97
M 0287 4c M 0288 8c M 0289 02            # JMP $028C
M 028a a9 M 028b ee                      # skipped by the jump
M 028c 85 M 028d 98 W 0098 84            # STA $98
M 028e 4c M 028f 8e M 0290 02            # JMP $028E  halt loop
H 028e

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module tb_cpu_core -o sim_tb_cpu_core
./obj_dir/sim_tb_cpu_core > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation passed"

// ==== src.f ====
cpu_pkg.sv
cpu_ctrl_if.sv
cpu_alu.sv
cpu_decode.sv
cpu_timing.sv
cpu_datapath.sv
cpu_core.sv
tb_cpu_core.sv

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;

    localparam int          half_period  = 10;
    localparam int          reset_cycles = 16;
    localparam int          drive_delay  = 1;
    localparam logic [15:0] reset_addr   = 16'h0200;
    localparam int          newline_char = 10;

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  data_i;
    logic [15:0] addr_o;
    logic [7:0]  data_o;
    logic        rw_o;
    logic        sync_o;

    logic [7:0]  mem [0:65535];
    logic [15:0] exp_addr_q [$];
    logic [7:0]  exp_data_q [$];
    logic [15:0] halt_addr;
    int          preload_count;
    int          write_idx;
    int          error_count;
    int          cycle_count = 0;
    int          cycle_limit;
    bit          vectors_ok;

    cpu_core cpu_core_inst (
        .clk    (clk),
        .rst    (rst),
        .data_i (data_i),
        .addr_o (addr_o),
        .data_o (data_o),
        .rw_o   (rw_o),
        .sync_o (sync_o)
    );

    always #(half_period) clk = ~clk;

    // memory answers reads in the same cycle
    assign data_i = mem[addr_o];

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (rw_o == 1'b0) begin
            mem[addr_o] <= data_o;
        end
    end

    task fill_memory;
        logic [15:0] fill_addr;
        for (int i = 0; i < 65536; i++) begin
            fill_addr = i[15:0];
            // both address bytes mixed in
            mem[fill_addr] <= fill_addr[15:8] ^ fill_addr[7:0] ^ 8'ha5;
        end
    endtask

    task load_vectors;
        int          fd;
        int          r;
        int          ch;
        logic [7:0]  kind;
        logic [15:0] rec_addr;
        logic [7:0]  rec_data;
        bit          halt_seen;
        bit          at_end;
        halt_seen = 1'b0;
        at_end = 1'b0;
        vectors_ok = 1'b0;
        fd = $fopen("cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open cpu_vectors.txt");
            error_count++;
        end else begin
            while (!at_end) begin
                r = $fscanf(fd, " %c", kind);
                if (r != 1) begin
                    at_end = 1'b1;
                end else if (kind == "#") begin
                    // comment runs to the end of the line
                    ch = $fgetc(fd);
                    while (ch != newline_char && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (kind == "M" || kind == "W") begin
                    r = $fscanf(fd, " %h %h", rec_addr, rec_data);
                    if (r != 2) begin
                        $display("malformed %c record in cpu_vectors.txt", kind);
                        error_count++;
                    end else if (kind == "M") begin
                        mem[rec_addr] <= rec_data;
                        preload_count++;
                    end else begin
                        exp_addr_q.push_back(rec_addr);
                        exp_data_q.push_back(rec_data);
                    end
                end else if (kind == "H") begin
                    r = $fscanf(fd, " %h", rec_addr);
                    halt_addr = rec_addr;
                    halt_seen = (r == 1);
                end else begin
                    $display("unknown record letter %c in cpu_vectors.txt", kind);
                    error_count++;
                end
            end
            $fclose(fd);
            if (!halt_seen) begin
                $display("cpu_vectors.txt has no usable halt line");
                error_count++;
            end else begin
                vectors_ok = 1'b1;
            end
        end
    endtask

    task check_write;
        if (write_idx >= exp_addr_q.size()) begin
            $display("unexpected write of %h to %h at %0t", data_o, addr_o, $time);
            error_count++;
        end else begin
            if (addr_o !== exp_addr_q[write_idx] || data_o !== exp_data_q[write_idx]) begin
                $display("** Error at %0t: write %0d expected %h to %h, got %h to %h",
                         $time, write_idx, exp_data_q[write_idx], exp_addr_q[write_idx],
                         data_o, addr_o);
                error_count++;
            end
            write_idx++;
        end
    endtask

    task run_program;
        int since_release;
        bit done;
        since_release = 0;
        done = 1'b0;
        cycle_limit = 4 * preload_count + reset_cycles + 50;

        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        if (rw_o !== 1'b1 || sync_o !== 1'b0 || addr_o !== 16'h0000 || data_o !== 8'h00) begin
            $display("** Error at %0t: reset state rw %b sync %b addr %h data %h, expected 1 0 0000 00",
                     $time, rw_o, sync_o, addr_o, data_o);
            error_count++;
        end
        @(posedge clk);
        #(drive_delay) rst = 1'b0;

        while (!done) begin
            @(negedge clk);
            since_release++;
            // first cycle after the edge that samples rst low
            if (since_release == 2) begin
                if (sync_o !== 1'b1 || addr_o !== reset_addr || rw_o !== 1'b1) begin
                    $display("** Error at %0t: first fetch sync %b addr %h rw %b, expected 1 %h 1",
                             $time, sync_o, addr_o, rw_o, reset_addr);
                    error_count++;
                end
            end
            if (rw_o === 1'b0) begin
                check_write();
            end
            if (sync_o === 1'b1 && addr_o === halt_addr) begin
                done = 1'b1;
                if (write_idx != exp_addr_q.size()) begin
                    $display("%0d expected writes never happened",
                             exp_addr_q.size() - write_idx);
                    error_count++;
                end
            end else if (cycle_count > cycle_limit) begin
                $display("timeout: halt address never fetched");
                error_count++;
                done = 1'b1;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        error_count = 0;
        write_idx = 0;
        preload_count = 0;
        halt_addr = '0;
        fill_memory();
        load_vectors();
        if (vectors_ok) begin
            run_program();
        end
        $display("errors: %0d, writes checked: %0d of %0d", error_count, write_idx,
                 exp_addr_q.size());
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
